/* Bender.yml */
package:
  name: miner_view

sources:
  - files:
      - verilog/miner_pkg.sv
      - verilog/object_table.sv
      - verilog/background_drawer.sv
      - verilog/sprite_drawer.sv
      - verilog/rope_drawer.sv
      - verilog/frame_sequencer.sv
      - verilog/pixel_arbiter.sv
      - verilog/miner_view.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/miner_view_tb.sv

/* test/frame_model.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected per-frame write counts of the renderer, by colour
// included inside the testbench module
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// rows above the ground line
function automatic int sky_pixels(input int w, input int ground);
	return w * ground;
endfunction

// ground line and everything below it
function automatic int earth_pixels(input int w, input int h, input int ground);
	return w * (h - ground);
endfunction

// one step per frame, clamped at both ends
function automatic int next_rope_len(input int len, input logic drop_lvl);
	int n;
	if (drop_lvl)
		n = len + miner_pkg::ROPE_STEP;
	else
		n = len - miner_pkg::ROPE_STEP;
	if (n > miner_pkg::ROPE_MAX)
		n = miner_pkg::ROPE_MAX;
	if (n < miner_pkg::ROPE_MIN)
		n = miner_pkg::ROPE_MIN;
	return n;
endfunction

// rope column plus the hook row
function automatic int rope_pixels(input int len);
	return len + miner_pkg::HOOK_W;
endfunction

// full square per visible object of that kind, empty kind never shows
function automatic int kind_pixels(input int kind,
	input logic [miner_pkg::NUM_OBJECTS-1:0] vis);
	int n;
	n = 0;
	if (kind == int'(miner_pkg::KIND_EMPTY))
		return 0;
	for (int i = 0; i < miner_pkg::NUM_OBJECTS; i++) begin
		if (int'(miner_pkg::OBJ_INIT[i].kind) == kind && vis[i])
			n += miner_pkg::SPRITE_SIZE * miner_pkg::SPRITE_SIZE;
	end
	return n;
endfunction

`endif

/* test/miner_view_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the frame renderer on a 32 x 24 screen, 4 frames per round
// tallies every frame's writes by colour against the frame model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module miner_view_tb;

	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 24;
	localparam int GROUND_Y = 8;
	localparam int ROUND_FRAMES = 4;
	localparam int NUM_TESTS = 6;
	localparam int FRAME_LIMIT = 5000;
	localparam int IW = $clog2(miner_pkg::NUM_OBJECTS);

	logic clk;
	logic resetn;
	logic go;
	logic drop;
	logic grab;
	logic [IW-1:0] grab_index;
	miner_pkg::coord_x_t x;
	miner_pkg::coord_y_t y;
	miner_pkg::color_t color;
	logic write_en;
	logic frame_done;
	logic round_over;

	// one round per row, drop bit i is the level during frame i
	// grab index -1 is no grab, -2 picks a random entry
	// rope stays at 20 or less so the hook row is on screen
	string test_name [NUM_TESTS] = '{"idle_rope", "drop_down", "reel_in",
		"mixed_drop", "grab_empty", "grab_last"};
	logic [ROUND_FRAMES-1:0] drop_bits [NUM_TESTS] = '{4'b0000, 4'b1111, 4'b0000,
		4'b0101, 4'b0110, 4'b0011};
	int grab_frame [NUM_TESTS] = '{0, 0, 1, 2, 0, 3};
	int grab_sel [NUM_TESTS] = '{-1, -1, 2, -2, 5, 7};

	int errors, test_errors, passed, failed;
	int rope_len;
	int seed_dummy;
	logic [miner_pkg::NUM_OBJECTS-1:0] vis_mask;
	bit abort;
	int cnt_sky, cnt_earth, cnt_rope, cnt_zero, cnt_other, cnt_off;
	int cnt_kind [4];

	`include "frame_model.svh"

	miner_view #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
		.GROUND_Y(GROUND_Y), .ROUND_FRAMES(ROUND_FRAMES)
	) dut0 (
		.clk(clk), .resetn(resetn), .go(go), .drop(drop),
		.grab(grab), .grab_index(grab_index),
		.x(x), .y(y), .color(color), .write_en(write_en),
		.frame_done(frame_done), .round_over(round_over)
	);

	always #2 clk = ~clk;

	task automatic clear_tally();
		cnt_sky = 0;
		cnt_earth = 0;
		cnt_rope = 0;
		cnt_zero = 0;
		cnt_other = 0;
		cnt_off = 0;
		for (int k = 0; k < 4; k++)
			cnt_kind[k] = 0;
	endtask

	task automatic tally_pixel();
		bit matched;
		matched = 1'b0;
		if (x >= SCREEN_W || y >= SCREEN_H)
			cnt_off++;
		if (color == '0) begin
			cnt_zero++;
		end else if (color == miner_pkg::SKY_COLOR) begin
			cnt_sky++;
		end else if (color == miner_pkg::EARTH_COLOR) begin
			cnt_earth++;
		end else if (color == miner_pkg::ROPE_COLOR) begin
			cnt_rope++;
		end else begin
			for (int k = 1; k < 4; k++) begin
				if (color == miner_pkg::KIND_COLOR[k]) begin
					cnt_kind[k]++;
					matched = 1'b1;
				end
			end
			if (!matched)
				cnt_other++;
		end
	endtask

	task automatic compare_count(input string name, input int f, input string what,
		input int expected, input int actual);
		assert (actual == expected) else begin
			$display("ERR %s frame %0d %s: expected %0d actual %0d",
				name, f, what, expected, actual);
			test_errors++;
		end
	endtask

	// port must stay quiet, round_over held at the given level
	task automatic check_idle(input string name, input int n, input logic over_level);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			assert (!write_en && !frame_done && round_over == over_level) else begin
				$display("%s: port not idle or round_over wrong while waiting for go", name);
				test_errors++;
			end
		end
	endtask

	task automatic start_round();
		@(posedge clk);
		#1;
		go = 1'b1;
		@(posedge clk);
		#1;
		go = 1'b0;
	endtask

	task automatic run_frame(input int t, input int f);
		int cycles;
		int idx;
		bit seen;
		logic grab_now;
		cycles = 0;
		seen = 1'b0;
		idx = 0;
		grab_now = grab_frame[t] == f && grab_sel[t] != -1;
		if (grab_now)
			idx = (grab_sel[t] == -2) ? int'($urandom % miner_pkg::NUM_OBJECTS) : grab_sel[t];
		clear_tally();
		while (!seen && cycles < FRAME_LIMIT) begin
			@(posedge clk);
			#1;
			drop = drop_bits[t][f];
			grab = grab_now && cycles == 0;
			grab_index = IW'(idx);
			@(negedge clk);
			if (write_en)
				tally_pixel();
			if (frame_done)
				seen = 1'b1;
			assert (frame_done || !round_over) else begin
				$display("%s frame %0d: round_over high before the frame ended",
					test_name[t], f);
				test_errors++;
			end
			cycles++;
		end
		if (!seen) begin
			$display("%s frame %0d: no frame_done within %0d cycles",
				test_name[t], f, FRAME_LIMIT);
			test_errors++;
			abort = 1'b1;
			return;
		end
		// advance the model to this frame
		if (grab_now)
			vis_mask[idx] = 1'b0;
		rope_len = next_rope_len(rope_len, drop_bits[t][f]);
		compare_count(test_name[t], f, "sky", sky_pixels(SCREEN_W, GROUND_Y), cnt_sky);
		compare_count(test_name[t], f, "earth",
			earth_pixels(SCREEN_W, SCREEN_H, GROUND_Y), cnt_earth);
		compare_count(test_name[t], f, "gold", kind_pixels(1, vis_mask), cnt_kind[1]);
		compare_count(test_name[t], f, "stone", kind_pixels(2, vis_mask), cnt_kind[2]);
		compare_count(test_name[t], f, "diamond", kind_pixels(3, vis_mask), cnt_kind[3]);
		compare_count(test_name[t], f, "rope", rope_pixels(rope_len), cnt_rope);
		compare_count(test_name[t], f, "transparent", 0, cnt_zero);
		compare_count(test_name[t], f, "unknown colour", 0, cnt_other);
		compare_count(test_name[t], f, "off screen", 0, cnt_off);
		compare_count(test_name[t], f, "round_over", f == ROUND_FRAMES - 1, round_over);
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			passed++;
			$display("test %s ok", name);
		end else begin
			failed++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
		errors += test_errors;
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		go = 1'b0;
		drop = 1'b0;
		grab = 1'b0;
		grab_index = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		abort = 1'b0;
		seed_dummy = $urandom(32'hc317d226);
		rope_len = miner_pkg::ROPE_MIN;
		for (int i = 0; i < miner_pkg::NUM_OBJECTS; i++)
			vis_mask[i] = miner_pkg::OBJ_INIT[i].visible;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		test_errors = 0;
		check_idle("reset_idle", 20, 1'b0);
		finish_test("reset_idle");

		for (int t = 0; t < NUM_TESTS; t++) begin
			if (abort)
				break;
			test_errors = 0;
			start_round();
			for (int f = 0; f < ROUND_FRAMES; f++) begin
				if (!abort)
					run_frame(t, f);
			end
			if (!abort)
				check_idle(test_name[t], 8, 1'b1);
			finish_test(test_name[t]);
		end

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0 && !abort)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+test
verilog/miner_pkg.sv
verilog/object_table.sv
verilog/background_drawer.sv
verilog/sprite_drawer.sv
verilog/rope_drawer.sv
verilog/frame_sequencer.sv
verilog/pixel_arbiter.sv
verilog/miner_view.sv
test/miner_view_tb.sv

/* verilog/background_drawer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster scan of the full screen, sky above the ground line, earth below
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module background_drawer #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int GROUND_Y = 80
) (
	input  logic clk,
	input  logic resetn,
	input  logic enable,
	output miner_pkg::coord_x_t px,
	output miner_pkg::coord_y_t py,
	output miner_pkg::color_t pcolor,
	output logic pvalid,
	output logic done
);

	logic finished;
	logic end_of_row;
	logic last;

	assign pvalid = enable && !finished;
	assign end_of_row = px == miner_pkg::coord_x_t'(SCREEN_W - 1);
	assign last = pvalid && end_of_row && py == miner_pkg::coord_y_t'(SCREEN_H - 1);

	assign pcolor = (py < miner_pkg::coord_y_t'(GROUND_Y)) ?
		miner_pkg::SKY_COLOR : miner_pkg::EARTH_COLOR;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			px <= '0;
			py <= '0;
			finished <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= last;
			if (!enable) begin
				// rearm for the next frame
				px <= '0;
				py <= '0;
				finished <= 1'b0;
			end else if (pvalid) begin
				if (last) begin
					px <= '0;
					py <= '0;
					finished <= 1'b1;
				end else if (end_of_row) begin
					px <= '0;
					py <= py + 1'b1;
				end else begin
					px <= px + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/frame_sequencer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round FSM: enables the drawers in order, counts frames, flags round end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module frame_sequencer #(
	parameter int ROUND_FRAMES = 60
) (
	input  logic clk,
	input  logic resetn,
	input  logic go,
	input  logic bg_done,
	input  logic sprite_done,
	input  logic rope_done,
	output logic bg_enable,
	output logic sprite_enable,
	output logic rope_enable,
	output logic frame_done,
	output logic round_over
);

	localparam int FW = $clog2(ROUND_FRAMES + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BG,
		S_SPRITES,
		S_ROPE,
		S_OVER
	} state_t;

	state_t state;
	logic [FW-1:0] frame_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			frame_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			// one cycle behind the rope drawer's done
			frame_done <= (state == S_ROPE) && rope_done;
			case (state)
				S_IDLE, S_OVER: begin
					if (go) begin
						state <= S_BG;
						frame_cnt <= '0;
					end
				end
				S_BG: begin
					if (bg_done)
						state <= S_SPRITES;
				end
				S_SPRITES: begin
					if (sprite_done)
						state <= S_ROPE;
				end
				S_ROPE: begin
					if (rope_done) begin
						if (frame_cnt == FW'(ROUND_FRAMES - 1)) begin
							state <= S_OVER;
						end else begin
							state <= S_BG;
							frame_cnt <= frame_cnt + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign bg_enable = state == S_BG;
	assign sprite_enable = state == S_SPRITES;
	assign rope_enable = state == S_ROPE;
	// held until the next go
	assign round_over = state == S_OVER;

endmodule

/* verilog/miner_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants of the miner frame renderer
// referenced by scoped names from every RTL block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package miner_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	// 4:4:4 rgb
	typedef logic [11:0] color_t;

	typedef enum logic [1:0] {
		KIND_EMPTY   = 2'd0,
		KIND_GOLD    = 2'd1,
		KIND_STONE   = 2'd2,
		KIND_DIAMOND = 2'd3
	} obj_kind_t;

	typedef struct packed {
		coord_x_t  x;
		coord_y_t  y;
		obj_kind_t kind;
		logic      visible;
	} obj_rec_t;

	localparam int NUM_OBJECTS = 8;
	localparam int SPRITE_SIZE = 4;

	// top-left corners, kept inside a 32 x 24 screen
	localparam obj_rec_t OBJ_INIT [NUM_OBJECTS] = '{
		'{x: 9'd2,  y: 8'd10, kind: KIND_GOLD,    visible: 1'b1},
		'{x: 9'd8,  y: 8'd12, kind: KIND_GOLD,    visible: 1'b1},
		'{x: 9'd14, y: 8'd10, kind: KIND_STONE,   visible: 1'b1},
		'{x: 9'd20, y: 8'd14, kind: KIND_STONE,   visible: 1'b1},
		'{x: 9'd26, y: 8'd16, kind: KIND_DIAMOND, visible: 1'b1},
		'{x: 9'd4,  y: 8'd18, kind: KIND_EMPTY,   visible: 1'b1},
		'{x: 9'd10, y: 8'd18, kind: KIND_GOLD,    visible: 1'b1},
		'{x: 9'd22, y: 8'd19, kind: KIND_STONE,   visible: 1'b1}
	};

	localparam color_t SKY_COLOR   = 12'h4af;
	localparam color_t EARTH_COLOR = 12'h852;
	localparam color_t ROPE_COLOR  = 12'h333;
	// empty kind is colour zero, dropped as transparent
	localparam color_t KIND_COLOR [4] = '{12'h000, 12'hfd0, 12'h999, 12'h0ef};

	localparam coord_x_t ANCHOR_X = 9'd16;
	localparam coord_y_t ANCHOR_Y = 8'd2;
	localparam int ROPE_MIN  = 4;
	localparam int ROPE_MAX  = 40;
	localparam int ROPE_STEP = 4;
	localparam int HOOK_W    = 5;

endpackage

/* verilog/miner_view.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// miner frame renderer top level, drives one shared pixel write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module miner_view #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int GROUND_Y = 80,
	parameter int ROUND_FRAMES = 60
) (
	input  logic clk,
	input  logic resetn,
	input  logic go,
	input  logic drop,
	input  logic grab,
	input  logic [$clog2(miner_pkg::NUM_OBJECTS)-1:0] grab_index,
	output miner_pkg::coord_x_t x,
	output miner_pkg::coord_y_t y,
	output miner_pkg::color_t color,
	output logic write_en,
	output logic frame_done,
	output logic round_over
);

	logic bg_enable, sprite_enable, rope_enable;
	logic bg_done, sprite_done, rope_done;
	logic bg_pvalid, sprite_pvalid, rope_pvalid;
	miner_pkg::coord_x_t bg_px, sprite_px, rope_px;
	miner_pkg::coord_y_t bg_py, sprite_py, rope_py;
	miner_pkg::color_t bg_pcolor, sprite_pcolor, rope_pcolor;
	miner_pkg::obj_rec_t record;
	logic [$clog2(miner_pkg::NUM_OBJECTS)-1:0] read_index;

	object_table table0 (
		.clk(clk), .resetn(resetn),
		.grab(grab), .grab_index(grab_index),
		.read_index(read_index), .record(record)
	);

	background_drawer #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .GROUND_Y(GROUND_Y)
	) bg0 (
		.clk(clk), .resetn(resetn), .enable(bg_enable),
		.px(bg_px), .py(bg_py), .pcolor(bg_pcolor),
		.pvalid(bg_pvalid), .done(bg_done)
	);

	sprite_drawer spr0 (
		.clk(clk), .resetn(resetn), .enable(sprite_enable),
		.record(record), .read_index(read_index),
		.px(sprite_px), .py(sprite_py), .pcolor(sprite_pcolor),
		.pvalid(sprite_pvalid), .done(sprite_done)
	);

	rope_drawer rope0 (
		.clk(clk), .resetn(resetn), .enable(rope_enable), .drop(drop),
		.px(rope_px), .py(rope_py), .pcolor(rope_pcolor),
		.pvalid(rope_pvalid), .done(rope_done)
	);

	frame_sequencer #(.ROUND_FRAMES(ROUND_FRAMES)) seq0 (
		.clk(clk), .resetn(resetn), .go(go),
		.bg_done(bg_done), .sprite_done(sprite_done), .rope_done(rope_done),
		.bg_enable(bg_enable), .sprite_enable(sprite_enable),
		.rope_enable(rope_enable),
		.frame_done(frame_done), .round_over(round_over)
	);

	// one register stage between the drawers and the port
	pixel_arbiter arb0 (
		.clk(clk), .resetn(resetn),
		.bg_px(bg_px), .bg_py(bg_py), .bg_pcolor(bg_pcolor), .bg_pvalid(bg_pvalid),
		.sprite_px(sprite_px), .sprite_py(sprite_py),
		.sprite_pcolor(sprite_pcolor), .sprite_pvalid(sprite_pvalid),
		.rope_px(rope_px), .rope_py(rope_py),
		.rope_pcolor(rope_pcolor), .rope_pvalid(rope_pvalid),
		.x(x), .y(y), .color(color), .write_en(write_en)
	);

endmodule

/* verilog/object_table.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object records of the round, read by the sprite drawer
// grab hides one entry from the next frame on
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module object_table (
	input  logic clk,
	input  logic resetn,
	input  logic grab,
	input  logic [$clog2(miner_pkg::NUM_OBJECTS)-1:0] grab_index,
	input  logic [$clog2(miner_pkg::NUM_OBJECTS)-1:0] read_index,
	output miner_pkg::obj_rec_t record
);

	miner_pkg::obj_rec_t entries [miner_pkg::NUM_OBJECTS];

	// reload the start layout on reset
	// afterwards only the visible bits change
	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < miner_pkg::NUM_OBJECTS; i++) begin
				entries[i] <= miner_pkg::OBJ_INIT[i];
			end
		end else if (grab) begin
			entries[grab_index].visible <= 1'b0;
		end
	end

	// combinational read port
	assign record = entries[read_index];

endmodule

/* verilog/pixel_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks one drawer's pixel per cycle and registers it onto the write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module pixel_arbiter (
	input  logic clk,
	input  logic resetn,
	input  miner_pkg::coord_x_t bg_px,
	input  miner_pkg::coord_y_t bg_py,
	input  miner_pkg::color_t bg_pcolor,
	input  logic bg_pvalid,
	input  miner_pkg::coord_x_t sprite_px,
	input  miner_pkg::coord_y_t sprite_py,
	input  miner_pkg::color_t sprite_pcolor,
	input  logic sprite_pvalid,
	input  miner_pkg::coord_x_t rope_px,
	input  miner_pkg::coord_y_t rope_py,
	input  miner_pkg::color_t rope_pcolor,
	input  logic rope_pvalid,
	output miner_pkg::coord_x_t x,
	output miner_pkg::coord_y_t y,
	output miner_pkg::color_t color,
	output logic write_en
);

	miner_pkg::coord_x_t sel_x;
	miner_pkg::coord_y_t sel_y;
	miner_pkg::color_t sel_color;
	logic sel_valid;

	// background first, then sprites, then rope
	always_comb begin
		sel_x = rope_px;
		sel_y = rope_py;
		sel_color = rope_pcolor;
		sel_valid = rope_pvalid;
		if (bg_pvalid) begin
			sel_x = bg_px;
			sel_y = bg_py;
			sel_color = bg_pcolor;
			sel_valid = 1'b1;
		end else if (sprite_pvalid) begin
			sel_x = sprite_px;
			sel_y = sprite_py;
			sel_color = sprite_pcolor;
			sel_valid = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		x <= sel_x;
		y <= sel_y;
		color <= sel_color;
	end

	// colour zero is transparent
	always_ff @(posedge clk) begin
		if (!resetn)
			write_en <= 1'b0;
		else
			write_en <= sel_valid && (sel_color != '0);
	end

endmodule

/* verilog/rope_drawer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vertical rope from the anchor with a short hook below its end
// length follows drop once per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rope_drawer (
	input  logic clk,
	input  logic resetn,
	input  logic enable,
	input  logic drop,
	output miner_pkg::coord_x_t px,
	output miner_pkg::coord_y_t py,
	output miner_pkg::color_t pcolor,
	output logic pvalid,
	output logic done
);

	localparam int CW = $clog2(miner_pkg::ROPE_MAX + miner_pkg::HOOK_W + 1);
	localparam logic [CW-1:0] LEN_MIN = CW'(miner_pkg::ROPE_MIN);
	localparam logic [CW-1:0] LEN_MAX = CW'(miner_pkg::ROPE_MAX);
	localparam logic [CW-1:0] LEN_STEP = CW'(miner_pkg::ROPE_STEP);
	localparam logic [CW-1:0] HOOK_LEN = CW'(miner_pkg::HOOK_W);
	localparam miner_pkg::coord_x_t HOOK_X0 =
		miner_pkg::ANCHOR_X - miner_pkg::coord_x_t'(miner_pkg::HOOK_W / 2);

	logic [CW-1:0] rope_len;
	logic [CW-1:0] cnt;
	logic [CW-1:0] hook_i;
	logic enable_q;
	logic start;
	logic finished;
	logic in_rope;
	logic last;

	assign start = enable && !enable_q;
	assign pvalid = enable && !finished;
	assign in_rope = cnt < rope_len;
	assign hook_i = cnt - rope_len;
	// first pixel is always rope, so the old length is fine on the start cycle
	assign last = pvalid && cnt == rope_len + HOOK_LEN - 1'b1;

	assign px = in_rope ? miner_pkg::ANCHOR_X : HOOK_X0 + miner_pkg::coord_x_t'(hook_i);
	assign py = miner_pkg::ANCHOR_Y +
		miner_pkg::coord_y_t'(in_rope ? cnt : rope_len);
	assign pcolor = miner_pkg::ROPE_COLOR;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rope_len <= LEN_MIN;
			cnt <= '0;
			enable_q <= 1'b0;
			finished <= 1'b0;
			done <= 1'b0;
		end else begin
			enable_q <= enable;
			done <= last;
			// drop sampled once, at the start of the rope pass
			if (start) begin
				if (drop) begin
					rope_len <= (rope_len >= LEN_MAX) ? LEN_MAX : rope_len + LEN_STEP;
				end else begin
					rope_len <= (rope_len <= LEN_MIN) ? LEN_MIN : rope_len - LEN_STEP;
				end
			end
			if (!enable) begin
				cnt <= '0;
				finished <= 1'b0;
			end else if (pvalid) begin
				cnt <= last ? '0 : cnt + 1'b1;
				finished <= last;
			end
		end
	end

endmodule

/* verilog/sprite_drawer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walks the object table and paints one square per entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sprite_drawer (
	input  logic clk,
	input  logic resetn,
	input  logic enable,
	input  miner_pkg::obj_rec_t record,
	output logic [$clog2(miner_pkg::NUM_OBJECTS)-1:0] read_index,
	output miner_pkg::coord_x_t px,
	output miner_pkg::coord_y_t py,
	output miner_pkg::color_t pcolor,
	output logic pvalid,
	output logic done
);

	localparam int IW = $clog2(miner_pkg::NUM_OBJECTS);
	localparam int OW = $clog2(miner_pkg::SPRITE_SIZE);

	logic [IW-1:0] obj_idx;
	logic [OW-1:0] off_x;
	logic [OW-1:0] off_y;
	logic scanning;
	logic finished;
	logic row_end;
	logic sprite_end;
	logic last;

	// hidden objects still take their slot, they are just not valid
	assign scanning = enable && !finished;
	assign row_end = off_x == OW'(miner_pkg::SPRITE_SIZE - 1);
	assign sprite_end = row_end && off_y == OW'(miner_pkg::SPRITE_SIZE - 1);
	assign last = scanning && sprite_end && obj_idx == IW'(miner_pkg::NUM_OBJECTS - 1);

	assign read_index = obj_idx;
	assign px = record.x + miner_pkg::coord_x_t'(off_x);
	assign py = record.y + miner_pkg::coord_y_t'(off_y);
	assign pcolor = miner_pkg::KIND_COLOR[record.kind];
	assign pvalid = scanning && record.visible;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			obj_idx <= '0;
			off_x <= '0;
			off_y <= '0;
			finished <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= last;
			if (!enable) begin
				obj_idx <= '0;
				off_x <= '0;
				off_y <= '0;
				finished <= 1'b0;
			end else if (scanning) begin
				if (last) begin
					finished <= 1'b1;
				end
				// offset counter, x fastest, then y, then object
				if (row_end) begin
					off_x <= '0;
					if (sprite_end) begin
						off_y <= '0;
						obj_idx <= last ? '0 : obj_idx + 1'b1;
					end else begin
						off_y <= off_y + 1'b1;
					end
				end else begin
					off_x <= off_x + 1'b1;
				end
			end
		end
	end

endmodule
